//--- nes_pkg.sv
// Shared types and constants for the CPU-side bus core
// Holds the bus structs, the address map, the system type and the DMA state encodings
// Modules take it with a wildcard import in their body
`default_nettype none

package nes_pkg;

	typedef logic [15:0] addr_t;   // CPU bus address
	typedef logic [7:0]  data_t;   // One data byte

	// What the CPU asks for in one cycle
	typedef struct packed {
		addr_t addr;
		logic  write;   // High for a store, low for a load
		data_t wdata;
	} cpu_req_t;

	// Request that reaches the bus after master select
	typedef struct packed {
		addr_t addr;
		logic  read;
		logic  write;
		data_t wdata;
	} bus_t;

	// Bid from the DMA engine, wins the bus when enable is set
	typedef struct packed {
		logic  enable;
		addr_t addr;
		logic  read;    // Low means a write of wdata
		data_t wdata;
	} dma_req_t;

	typedef enum logic {sys_ntsc, sys_pal} sys_type_t;

	// Bit 0 set in both busy states, so it doubles as the CPU halt
	typedef enum logic [1:0] {spr_idle = 2'b00, spr_wait = 2'b01, spr_run = 2'b11} spr_state_t;
	typedef enum logic {dmc_idle, dmc_fetch} dmc_state_t;

	// Address map
	localparam addr_t oam_data_addr   = 16'h2004;   // PPU sprite data port
	localparam addr_t oam_dma_addr    = 16'h4014;   // Sprite DMA page write
	localparam addr_t apu_status_addr = 16'h4015;
	localparam addr_t joy1_addr       = 16'h4016;   // Strobe on write, port 1 on read
	localparam addr_t joy2_addr       = 16'h4017;
	localparam addr_t apu_base        = 16'h4000;
	localparam addr_t apu_end         = 16'h4017;   // Inclusive

	localparam int PAL_STRETCH_PERIOD = 5;   // One long CPU cycle per this many in PAL

	// Defaults picked up by the top level parameters
	localparam int DEF_CPU_DIV  = 12;
	localparam int DEF_PPU_DIV  = 4;
	localparam int DEF_JOY_BITS = 5;

endpackage

`default_nettype wire

//--- clock_divider.sv
// Clock-enable generator for the CPU side of the core
// Divides the master clock into CPU, PPU and M2 enables, tracks even/odd CPU cycles
// and holds the CPU in reset until its first enable
`timescale 1ns/10ps
`default_nettype none

module clock_divider #(
	parameter int CPU_DIV = 12,
	parameter int PPU_DIV = 4
) (
	input  logic                clk,
	input  logic                reset,
	input  nes_pkg::sys_type_t  sys_type,
	output logic                cpu_ce,
	output logic                ppu_ce,
	output logic                m2,
	output logic                odd_cycle,
	output logic                cpu_reset
);
	import nes_pkg::*;

	localparam int CPU_W    = $clog2(CPU_DIV + 1);
	localparam int PPU_W    = $clog2(PPU_DIV + 1);
	localparam int PAL_W    = $clog2(PAL_STRETCH_PERIOD);
	localparam int M2_RISE  = (CPU_DIV * 5) / 12;   // Count where M2 goes high

	logic [CPU_W-1:0] div_cpu;    // 1..CPU_DIV
	logic [PPU_W-1:0] div_ppu;    // 1..PPU_DIV
	logic [1:0]       ppu_tick;   // PPU ticks since the last cpu_ce
	logic [PAL_W-1:0] pal_cnt;    // Position in the PAL five-cycle group
	sys_type_t        last_sys;
	logic             sys_change;
	logic             stretch;    // Hold the CPU divider for one PPU tick

	assign cpu_ce = (div_cpu == CPU_W'(CPU_DIV));
	assign ppu_ce = (div_ppu == PPU_W'(PPU_DIV));
	assign m2     = (div_cpu >= CPU_W'(M2_RISE)) && !cpu_ce;   // Low on the cpu_ce clock

	assign sys_change = (last_sys != sys_type);

	// Last cycle of the group waits out its first PPU tick
	assign stretch = (sys_type == sys_pal) &&
		(pal_cnt == PAL_W'(PAL_STRETCH_PERIOD - 1)) && (ppu_tick == 2'd0);

	always_ff @(posedge clk) begin
		if (reset) begin
			div_cpu   <= CPU_W'(1);
			div_ppu   <= PPU_W'(1);
			ppu_tick  <= 2'd0;
			pal_cnt   <= '0;
			last_sys  <= sys_type;   // No realign straight out of reset
			odd_cycle <= 1'b1;
			cpu_reset <= 1'b1;
		end else begin
			last_sys <= sys_type;
			if (sys_change) begin
				// Start everything over from count 1
				div_cpu  <= CPU_W'(1);
				div_ppu  <= PPU_W'(1);
				ppu_tick <= 2'd0;
				pal_cnt  <= '0;
			end else begin
				if (!stretch)
					div_cpu <= cpu_ce ? CPU_W'(1) : div_cpu + CPU_W'(1);
				div_ppu <= ppu_ce ? PPU_W'(1) : div_ppu + PPU_W'(1);
				if (cpu_ce)
					ppu_tick <= 2'd0;   // First tick of the new CPU cycle
				else if (ppu_ce)
					ppu_tick <= ppu_tick + 2'd1;
				if (cpu_ce && sys_type == sys_pal)
					pal_cnt <= (pal_cnt == PAL_W'(PAL_STRETCH_PERIOD - 1)) ? '0 : pal_cnt + PAL_W'(1);
			end
			if (cpu_ce) begin
				odd_cycle <= ~odd_cycle;
				cpu_reset <= 1'b0;   // Released by the first CPU cycle
			end
		end
	end

endmodule

`default_nettype wire

//--- oam_dma.sv
// Sprite and DMC sample DMA engine
// Steals CPU cycles on cpu_ce: sprite copies alternate even reads and odd writes to
// the OAM data port, DMC fetches take a single even read and preempt the sprite copy
`timescale 1ns/10ps
`default_nettype none

module oam_dma (
	input  logic                clk,
	input  logic                reset,
	input  logic                cpu_ce,
	input  logic                odd_cycle,
	input  logic                sprite_trigger,   // CPU wrote the page register
	input  logic                cpu_read,         // CPU cycle is a load
	input  nes_pkg::data_t      sprite_page,
	input  logic                dmc_request,
	input  nes_pkg::addr_t      dmc_addr,
	input  nes_pkg::data_t      bus_rdata,
	output nes_pkg::dma_req_t   dma_req,
	output logic                dmc_ack,
	output logic                pause_cpu
);
	import nes_pkg::*;

	spr_state_t spr_state;
	dmc_state_t dmc_state;
	addr_t      spr_addr;    // Source address of the next sprite byte
	data_t      spr_byte;    // Last byte read, written on the odd cycle
	logic [8:0] next_low;    // Low byte plus one, bit 8 ends the copy
	logic       spr_read;

	assign next_low = {1'b0, spr_addr[7:0]} + 9'd1;
	assign dmc_ack  = (dmc_state == dmc_fetch) && !odd_cycle;
	assign spr_read = (spr_state == spr_run) && !odd_cycle && !dmc_ack;

	// Sprite wait or run halts the CPU, a DMC request halts it at once
	assign pause_cpu = (spr_state != spr_idle) || dmc_request;

	always_comb begin
		dma_req.enable = dmc_ack || (spr_state == spr_run);
		dma_req.read   = !odd_cycle;   // Reads even, writes odd
		dma_req.wdata  = spr_byte;
		if (dmc_ack)
			dma_req.addr = dmc_addr;   // DMC first
		else if (!odd_cycle)
			dma_req.addr = spr_addr;
		else
			dma_req.addr = oam_data_addr;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			spr_state <= spr_idle;
			dmc_state <= dmc_idle;
		end else if (cpu_ce) begin
			case (dmc_state)
				dmc_idle:
					if (dmc_request && cpu_read && !odd_cycle)
						dmc_state <= dmc_fetch;   // Odd cycle idle, then the even fetch
				dmc_fetch:
					if (!odd_cycle)
						dmc_state <= dmc_idle;
				default: dmc_state <= dmc_idle;
			endcase

			if (sprite_trigger) begin
				spr_state <= spr_wait;
			end else begin
				case (spr_state)
					spr_wait:
						if (cpu_read && odd_cycle)
							spr_state <= spr_run;   // Align so the copy starts even
					spr_run:
						if (!odd_cycle && dmc_state == dmc_fetch)
							spr_state <= spr_wait;   // DMC took this read, redo it later
						else if (odd_cycle && next_low[8])
							spr_state <= spr_idle;   // Wrote byte 255
					default: ;
				endcase
			end
		end
	end

	// Source address and data byte
	always_ff @(posedge clk) begin
		if (cpu_ce) begin
			if (sprite_trigger)
				spr_addr <= {sprite_page, 8'h00};
			else if (spr_state == spr_run && odd_cycle)
				spr_addr[7:0] <= next_low[7:0];   // Step after each write
			if (spr_read)
				spr_byte <= bus_rdata;
		end
	end

endmodule

`default_nettype wire

//--- cpu_io_bus.sv
// CPU-side I/O bus
// Picks DMA or CPU as bus master, decodes PPU, APU and joypad selects,
// keeps the joypad strobe latch and builds the read data with open-bus hold
`timescale 1ns/10ps
`default_nettype none

module cpu_io_bus #(
	parameter int JOY_BITS = 5
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  cpu_ce,
	input  logic                  cpu_reset,
	input  nes_pkg::cpu_req_t     cpu_req,
	input  nes_pkg::dma_req_t     dma_req,
	input  nes_pkg::data_t        mem_rdata,
	input  nes_pkg::data_t        ppu_rdata,
	input  nes_pkg::data_t        apu_status,
	input  logic [JOY_BITS-1:0]   joypad1_data,
	input  logic [JOY_BITS-1:0]   joypad2_data,
	output nes_pkg::bus_t         bus,
	output nes_pkg::data_t        bus_rdata,
	output nes_pkg::data_t        cpu_rdata,
	output logic                  sprite_trigger,
	output logic                  ppu_cs,
	output logic                  apu_cs,
	output logic [2:0]            joypad_out,
	output logic [1:0]            joypad_clock
);
	import nes_pkg::*;

	data_t open_bus;   // Value left on the data bus by the last clock
	data_t rdata;
	logic  joy1_cs;
	logic  joy2_cs;

	// Bus master select
	always_comb begin
		if (dma_req.enable) begin
			bus.addr  = dma_req.addr;
			bus.read  = dma_req.read;
			bus.write = !dma_req.read;
			bus.wdata = dma_req.wdata;
		end else begin
			bus.addr  = cpu_req.addr;
			bus.read  = !cpu_req.write;
			bus.write = cpu_req.write;
			bus.wdata = cpu_req.wdata;
		end
	end

	// Address decode
	assign ppu_cs  = (bus.addr[15:13] == 3'b001);   // 0x2000-0x3FFF with mirrors
	assign apu_cs  = (bus.addr >= apu_base) && (bus.addr <= apu_end);
	assign joy1_cs = (bus.addr == joy1_addr);
	assign joy2_cs = (bus.addr == joy2_addr);

	// One strobe per CPU cycle
	assign sprite_trigger = cpu_ce && bus.write && (bus.addr == oam_dma_addr);

	assign joypad_clock = {joy2_cs && bus.read, joy1_cs && bus.read};

	always_ff @(posedge clk) begin
		if (reset)
			joypad_out <= 3'd0;
		else if (cpu_ce && bus.write && joy1_cs)
			joypad_out <= bus.wdata[2:0];   // Strobe bits for both pads
	end

	// Read data, undriven bits keep what was last on the bus
	always_comb begin
		if (reset || cpu_reset)
			rdata = '0;
		else if (apu_cs) begin
			if (joy1_cs)
				rdata = {open_bus[7:JOY_BITS], joypad1_data};
			else if (joy2_cs)
				rdata = {open_bus[7:JOY_BITS], joypad2_data};
			else if (bus.addr == apu_status_addr)
				rdata = apu_status;
			else
				rdata = open_bus;   // Write-only APU registers
		end else if (ppu_cs)
			rdata = ppu_rdata;
		else
			rdata = mem_rdata;
	end

	always_ff @(posedge clk) begin
		open_bus <= rdata;
	end

	assign bus_rdata = rdata;
	assign cpu_rdata = rdata;   // Same byte goes back to the CPU

endmodule

`default_nettype wire

//--- nes_core.sv
// Top level of the CPU-side bus core
// Connects the clock divider, the DMA engine and the I/O bus; the CPU, PPU, APU
// and memory sit outside and talk through these ports
`timescale 1ns/10ps
`default_nettype none

module nes_core #(
	parameter int CPU_DIV  = nes_pkg::DEF_CPU_DIV,
	parameter int PPU_DIV  = nes_pkg::DEF_PPU_DIV,
	parameter int JOY_BITS = nes_pkg::DEF_JOY_BITS
) (
	input  logic                  clk,
	input  logic                  reset,
	input  nes_pkg::sys_type_t    sys_type,
	input  nes_pkg::cpu_req_t     cpu_req,
	input  logic                  dmc_request,
	input  nes_pkg::addr_t        dmc_addr,
	input  nes_pkg::data_t        mem_rdata,
	input  nes_pkg::data_t        ppu_rdata,
	input  nes_pkg::data_t        apu_status,
	input  logic [JOY_BITS-1:0]   joypad1_data,
	input  logic [JOY_BITS-1:0]   joypad2_data,
	output logic                  cpu_ce,
	output logic                  ppu_ce,
	output logic                  m2,
	output logic                  odd_cycle,
	output logic                  cpu_reset,
	output logic                  pause_cpu,
	output logic                  dmc_ack,
	output nes_pkg::bus_t         bus,
	output nes_pkg::data_t        cpu_rdata,
	output logic                  ppu_cs,
	output logic                  apu_cs,
	output logic [2:0]            joypad_out,
	output logic [1:0]            joypad_clock
);
	import nes_pkg::*;

	dma_req_t dma_req;          // DMA bid for the bus
	logic     sprite_trigger;   // Write to the sprite page register
	data_t    bus_rdata;        // Read data as seen by the DMA engine

	clock_divider #(.CPU_DIV(CPU_DIV), .PPU_DIV(PPU_DIV)) u_clock_divider (
		.clk       (clk),
		.reset     (reset),
		.sys_type  (sys_type),
		.cpu_ce    (cpu_ce),
		.ppu_ce    (ppu_ce),
		.m2        (m2),
		.odd_cycle (odd_cycle),
		.cpu_reset (cpu_reset)
	);

	oam_dma u_oam_dma (
		.clk            (clk),
		.reset          (reset),
		.cpu_ce         (cpu_ce),
		.odd_cycle      (odd_cycle),
		.sprite_trigger (sprite_trigger),
		.cpu_read       (!cpu_req.write),
		.sprite_page    (cpu_req.wdata),   // Page byte of the trigger write
		.dmc_request    (dmc_request),
		.dmc_addr       (dmc_addr),
		.bus_rdata      (bus_rdata),
		.dma_req        (dma_req),
		.dmc_ack        (dmc_ack),
		.pause_cpu      (pause_cpu)
	);

	cpu_io_bus #(.JOY_BITS(JOY_BITS)) u_cpu_io_bus (
		.clk            (clk),
		.reset          (reset),
		.cpu_ce         (cpu_ce),
		.cpu_reset      (cpu_reset),
		.cpu_req        (cpu_req),
		.dma_req        (dma_req),
		.mem_rdata      (mem_rdata),
		.ppu_rdata      (ppu_rdata),
		.apu_status     (apu_status),
		.joypad1_data   (joypad1_data),
		.joypad2_data   (joypad2_data),
		.bus            (bus),
		.bus_rdata      (bus_rdata),
		.cpu_rdata      (cpu_rdata),
		.sprite_trigger (sprite_trigger),
		.ppu_cs         (ppu_cs),
		.apu_cs         (apu_cs),
		.joypad_out     (joypad_out),
		.joypad_clock   (joypad_clock)
	);

endmodule

`default_nettype wire

//--- nes_core_properties.sv
// Concurrent checks on the bus core, bound into every nes_core
// Enable alignment, DMC reads, DMA bus ownership and pause release timing
`timescale 1ns/10ps
`default_nettype none

module nes_core_properties (
	input logic          clk,
	input logic          reset,
	input logic          cpu_ce,
	input logic          ppu_ce,
	input logic          dmc_ack,
	input logic          pause_cpu,
	input logic          dma_enable,   // DMA engine owns the bus
	input nes_pkg::bus_t bus
);
	int fail_count = 0;

	cpu_on_ppu: assert property (@(posedge clk) disable iff (reset) cpu_ce |-> ppu_ce)
		else begin
			$error("cpu_ce without ppu_ce");
			fail_count++;
		end

	dmc_is_read: assert property (@(posedge clk) disable iff (reset) dmc_ack |-> bus.read)
		else begin
			$error("dmc_ack on a cycle that is not a bus read");
			fail_count++;
		end

	dma_halts_cpu: assert property (@(posedge clk) disable iff (reset) dma_enable |-> pause_cpu)
		else begin
			$error("DMA owns the bus while the CPU runs");
			fail_count++;
		end

	// The CPU is only let go at the end of a CPU cycle
	pause_on_ce: assert property (@(posedge clk) disable iff (reset)
		$fell(pause_cpu) |-> $past(cpu_ce))
		else begin
			$error("pause_cpu fell in the middle of a CPU cycle");
			fail_count++;
		end

endmodule

bind nes_core nes_core_properties u_props (
	.clk        (clk),
	.reset      (reset),
	.cpu_ce     (cpu_ce),
	.ppu_ce     (ppu_ce),
	.dmc_ack    (dmc_ack),
	.pause_cpu  (pause_cpu),
	.dma_enable (dma_req.enable),
	.bus        (bus)
);

`default_nettype wire

//--- tb_nes_core.sv
// Testbench for the CPU-side bus core
// Plays the CPU with seeded random traffic, answers memory reads with an address hash,
// and checks enables, sprite and DMC DMA, joypad and read data against a model
`timescale 1ns/10ps
`default_nettype none

module tb_nes_core;
	import nes_pkg::*;

	localparam int    JOY_BITS   = 5;
	localparam int    MAX_CLOCKS = 60000;      // About 2100 CPU cycles of tests at 12 clocks, with margin
	localparam addr_t HOLD_ADDR  = 16'h8000;   // CPU read while halted

	logic                clk = 1'b0;
	logic                reset;
	sys_type_t           sys_type;
	cpu_req_t            cpu_req;
	logic                dmc_request;
	addr_t               dmc_addr;
	data_t               mem_rdata, ppu_rdata, apu_status;
	logic [JOY_BITS-1:0] joypad1_data, joypad2_data;
	logic                cpu_ce, ppu_ce, m2, odd_cycle, cpu_reset, pause_cpu, dmc_ack;
	bus_t                bus;
	data_t               cpu_rdata;
	logic                ppu_cs, apu_cs;
	logic [2:0]          joypad_out;
	logic [1:0]          joypad_clock;

	int        errors = 0;
	int        cycles = 0;
	int        gap, ppu_gap, pal_pos;   // Clocks since the last enables, PAL group position
	logic      seen_ce = 1'b0;
	logic      odd_model = 1'b1;
	sys_type_t prev_sys = sys_ntsc;
	data_t     model_open = '0;         // Expected open-bus register
	logic [2:0] joy_model = '0;
	logic      spr_active = 1'b0;       // Sprite copy in flight
	logic      spr_phase;               // 0 expects the read, 1 the OAM write
	logic      pause_check = 1'b0;
	int        spr_n, spr_done = 0, dmc_seen = 0;
	data_t     spr_page, spr_last;

	nes_core #(.JOY_BITS(JOY_BITS)) UUT (.*);

	always #10 clk = ~clk;

	// Memory responder, byte depends on every address bit
	function automatic data_t mem_hash(input addr_t a);
		return {a[3:0], a[7:4]} ^ a[15:8] ^ 8'h5a;
	endfunction

	// Read data rules in priority order
	function automatic data_t expected_rdata(input addr_t a, input data_t ob, input logic quiet);
		if (quiet)                        return '0;
		if (a == 16'h4016)                return {ob[7:JOY_BITS], joypad1_data};
		if (a == 16'h4017)                return {ob[7:JOY_BITS], joypad2_data};
		if (a == 16'h4015)                return apu_status;
		if (a >= 16'h4000 && a <= 16'h4017) return ob;   // Write-only APU space
		if (a[15:13] == 3'b001)           return ppu_rdata;
		return mem_hash(a);
	endfunction

	assign mem_rdata = mem_hash(bus.addr);

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			errors++;
			$display("error: %s expected %0h actual %0h at %0t", name, exp, act, $time);
		end
	endtask

	// Follows DMA traffic at the end of each CPU cycle
	task automatic track_dma(input data_t rd);
		if (dmc_ack) begin
			check("dmc read", 1, bus.read);
			check("dmc address", dmc_addr, bus.addr);
			dmc_seen++;
		end else if (spr_active && !(bus.read && bus.addr == HOLD_ADDR)) begin
			if (!spr_phase) begin
				check("sprite read", 1, bus.read);
				check("sprite source", {spr_page, spr_n[7:0]}, bus.addr);
				spr_last = rd;   // Byte the engine latches
			end else begin
				check("sprite write", 1, bus.write);
				check("oam address", oam_data_addr, bus.addr);
				check("oam data", spr_last, bus.wdata);
				spr_n++;
				if (spr_n == 256) begin
					spr_active = 1'b0;
					pause_check = 1'b1;
					spr_done++;
				end
			end
			spr_phase = !spr_phase;
		end
		if (cpu_req.write && cpu_req.addr == oam_dma_addr) begin
			spr_active = 1'b1;
			spr_n = 0;
			spr_phase = 1'b0;
			spr_page = cpu_req.wdata;
		end
	endtask

	always @(negedge clk) begin
		data_t exp_rd;
		exp_rd = expected_rdata(bus.addr, model_open, reset || !seen_ce);
		check("read data", exp_rd, cpu_rdata);
		model_open = exp_rd;   // Loaded at the next edge
		check("ppu select", bus.addr[15:13] == 3'b001, ppu_cs);
		check("apu select", bus.addr >= 16'h4000 && bus.addr <= 16'h4017, apu_cs);
		check("joypad clock", {bus.read && bus.addr == 16'h4017,
			bus.read && bus.addr == 16'h4016}, joypad_clock);
		check("joypad out", joy_model, joypad_out);
		if (!spr_active && !dmc_request)   // CPU owns the bus outside DMA
			check("cpu bus", {cpu_req.addr, !cpu_req.write, cpu_req.write, cpu_req.wdata}, bus);
		if (spr_active)
			check("pause during copy", 1, pause_cpu);
		else if (pause_check)
			check("pause release", 0, pause_cpu);
		pause_check = 1'b0;
		if (reset) begin
			gap = 0;
			ppu_gap = 0;
			pal_pos = 0;
		end else begin
			gap++;
			ppu_gap++;
			check("cpu enable", gap == ((sys_type == sys_pal && pal_pos == 4) ? 16 : 12), cpu_ce);
			check("ppu enable", ppu_gap == 4, ppu_ce);
			if (sys_type == sys_ntsc && prev_sys == sys_ntsc)
				check("m2", gap >= 5 && gap <= 11, m2);
			check("cpu reset", !seen_ce, cpu_reset);
			check("odd cycle", odd_model, odd_cycle);
			if (ppu_ce)
				ppu_gap = 0;
			if (cpu_ce) begin
				gap = 0;
				seen_ce = 1'b1;
				odd_model = !odd_model;
				if (sys_type == sys_pal)
					pal_pos = (pal_pos + 1) % 5;
				track_dma(exp_rd);
				if (cpu_req.write && cpu_req.addr == joy1_addr)
					joy_model = cpu_req.wdata[2:0];
			end
			if (sys_type != prev_sys) begin   // Counters restart at the next edge
				gap = 0;
				ppu_gap = 0;
				pal_pos = 0;
			end
		end
		prev_sys = sys_type;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CLOCKS) begin
			$display("timeout: run still going after %0d clocks", MAX_CLOCKS);
			$display("test failed");
			$finish;
		end
	end

	// Returns 2 ns after the edge that ends the current CPU cycle
	task automatic next_cycle;
		@(negedge clk);
		while (!cpu_ce) @(negedge clk);
		@(posedge clk);
		#2;
	endtask

	task automatic cpu_step;
		int kind;
		kind = $urandom_range(0, 7);
		ppu_rdata = 8'($urandom);
		apu_status = 8'($urandom);
		joypad1_data = JOY_BITS'($urandom);
		joypad2_data = JOY_BITS'($urandom);
		if (pause_cpu || dmc_request) begin
			cpu_req.addr = HOLD_ADDR;   // Halted CPU keeps reading
			cpu_req.write = 1'b0;
		end else begin
			case (kind)
				0, 1: cpu_req.addr = {5'b0, 11'($urandom)};
				2:    cpu_req.addr = {3'b001, 13'($urandom)};
				3:    cpu_req.addr = 16'h4000 + 16'($urandom_range(0, 23));
				4:    cpu_req.addr = 16'h4016 + 16'($urandom_range(0, 1));
				default: cpu_req.addr = {1'b1, 15'($urandom)};
			endcase
			if (cpu_req.addr == oam_dma_addr)
				cpu_req.addr = apu_status_addr;   // Sprite copies only on purpose
			cpu_req.write = ($urandom_range(0, 3) == 0);
			cpu_req.wdata = 8'($urandom);
		end
		next_cycle();
	endtask

	task automatic sprite_copy(input logic steal);
		int start;
		int at;
		int want;
		start = spr_done;
		at = $urandom_range(20, 400);
		want = dmc_seen + 1;
		cpu_req.addr = oam_dma_addr;
		cpu_req.write = 1'b1;
		cpu_req.wdata = 8'($urandom_range(0, 127));   // Keeps clear of the hold address
		next_cycle();
		for (int k = 0; spr_done == start; k++) begin
			if (steal && k == at) begin
				dmc_request = 1'b1;
				dmc_addr = {2'b11, 14'($urandom)};
			end
			if (dmc_request && dmc_seen == want)
				dmc_request = 1'b0;
			cpu_step();
		end
	endtask

	initial begin
		void'($urandom(46708));
		reset = 1'b1;
		sys_type = sys_ntsc;
		cpu_req = '{addr: HOLD_ADDR, write: 1'b0, wdata: 8'h00};
		dmc_request = 1'b0;
		dmc_addr = '0;
		ppu_rdata = '0;
		apu_status = '0;
		joypad1_data = '0;
		joypad2_data = '0;
		repeat (8) @(posedge clk);
		#2 reset = 1'b0;
		repeat (200) cpu_step();
		sys_type = sys_pal;
		repeat (100) cpu_step();
		sys_type = sys_ntsc;
		repeat (50) cpu_step();
		sprite_copy(1'b0);
		sprite_copy(1'b1);
		sprite_copy(1'b1);
		repeat (100) cpu_step();
		check("dmc fetches", 2, dmc_seen);
		$display("errors: %0d, assertion failures: %0d", errors, UUT.u_props.fail_count);
		if (errors == 0 && UUT.u_props.fail_count == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
nes_pkg.sv
clock_divider.sv
oam_dma.sv
cpu_io_bus.sv
nes_core.sv
nes_core_properties.sv
tb_nes_core.sv

//--- Makefile
# Verilator build and run of the bus core testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_nes_core -Mdir obj_dir -f list.f
	./obj_dir/Vtb_nes_core +verilator+error+limit+1000 > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "test failed" $(LOG) || ! grep -q "test passed" $(LOG); then \
		echo "FAIL"; exit 1; \
	else \
		echo "PASS"; \
	fi

clean:
	rm -rf obj_dir $(LOG)
